/* source/snes_map_defines.svh */
`ifndef SNES_MAP_DEFINES_SVH
`define SNES_MAP_DEFINES_SVH

////////////////////
// Bus widths
////////////////////

`define SNES_ADDR_W 24

// Bit positions in featurebits
`define FEAT_DSPX 0
`define FEAT_SRTC 2
`define FEAT_MSU1 3
`define FEAT_213F 4

////////////////////
// Memory layout
////////////////////

`define SAVERAM_BASE  24'hE00000  // Save RAM lives at the top of memory
`define MENU_ROM_BASE 24'hC00000  // Menu ROM sits below save RAM

`endif

/* source/snes_map_pkg.sv */
`default_nettype none

package snes_map_pkg;

  // Mapper codes as reported by the MCU
  typedef enum logic [2:0] {
    mapper_hirom   = 3'd0,
    mapper_lorom   = 3'd1,
    mapper_exhirom = 3'd2,  // 48 to 64 Mbit
    mapper_menu    = 3'd7   // Menu ROM in upper memory
  } mapper_e;

  // Memory region an access falls into
  typedef enum logic [1:0] {
    region_none    = 2'd0,
    region_rom     = 2'd1,
    region_saveram = 2'd2
  } region_e;

  // Access opcode
  typedef enum logic {
    acc_read  = 1'b0,
    acc_write = 1'b1
  } access_e;

endpackage

`default_nettype wire

/* source/map_stage_if.sv */
`default_nettype none
`include "snes_map_defines.svh"

interface map_stage_if;
  import snes_map_pkg::*;

  logic                    valid;      // One-cycle pulse
  access_e                 kind;
  logic [`SNES_ADDR_W-1:0] snes_addr;
  logic [7:0]              snes_pa;
  region_e                 region;
  logic                    writable;
  logic [`SNES_ADDR_W-1:0] mem_addr;
  logic [5:0]              sel;        // msu, srtc, dspx, dspx_a0, r213f, cmd

  modport src (
    output valid, kind, snes_addr, snes_pa, region, writable, mem_addr, sel
  );

  modport dst (
    input valid, kind, snes_addr, snes_pa, region, writable, mem_addr, sel
  );

endinterface

`default_nettype wire

/* source/bus_capture.sv */
`default_nettype none
`include "snes_map_defines.svh"

module bus_capture (
  input  logic                    CLK,
  input  logic                    reset,
  input  logic [`SNES_ADDR_W-1:0] snes_addr,
  input  logic [7:0]              snes_pa,
  input  logic                    snes_rd,
  input  logic                    snes_wr,
  map_stage_if.src                out
);
  import snes_map_pkg::*;

  logic [`SNES_ADDR_W-1:0] addr_q;
  logic [7:0]              pa_q;
  logic                    rd_q;
  logic                    wr_q;
  logic                    strobe_prev;
  logic                    strobe_rise;

  assign strobe_rise = (rd_q | wr_q) & ~strobe_prev;

  // Sample the bus on every edge
  always_ff @(posedge CLK) begin
    addr_q <= snes_addr;
    pa_q   <= snes_pa;
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      rd_q        <= 1'b0;
      wr_q        <= 1'b0;
      strobe_prev <= 1'b0;
      out.valid   <= 1'b0;
    end else begin
      rd_q        <= snes_rd;
      wr_q        <= snes_wr;
      strobe_prev <= rd_q | wr_q;
      out.valid   <= strobe_rise;  // One pulse per strobe
    end
  end

  always_ff @(posedge CLK) begin
    if (strobe_rise) begin
      out.snes_addr <= addr_q;
      out.snes_pa   <= pa_q;
      out.kind      <= wr_q ? acc_write : acc_read;
    end
  end

  // Fields owned by later stages
  assign out.region   = region_none;
  assign out.writable = 1'b0;
  assign out.mem_addr = '0;
  assign out.sel      = '0;

  a_single_pulse : assert property (@(posedge CLK) disable iff (reset)
    out.valid |=> !out.valid);

endmodule

`default_nettype wire

/* source/address_decode.sv */
`default_nettype none
`include "snes_map_defines.svh"

module address_decode (
  input  logic                    CLK,
  input  logic                    reset,
  input  snes_map_pkg::mapper_e   mapper,
  input  logic [7:0]              featurebits,
  input  logic [`SNES_ADDR_W-1:0] saveram_mask,
  input  logic [`SNES_ADDR_W-1:0] rom_mask,
  map_stage_if.dst                in,
  map_stage_if.src                out
);
  import snes_map_pkg::*;

  logic [`SNES_ADDR_W-1:0] addr;
  logic                    sram_window;
  logic                    is_saveram;
  logic                    is_rom;
  region_e                 region_d;
  logic                    msu;
  logic                    srtc;
  logic                    dspx;
  logic                    dspx_a0;
  logic                    r213f;
  logic                    cmd;

  assign addr = in.snes_addr;

  ////////////////////
  // Region
  ////////////////////

  always_comb begin
    case (mapper)
      // SRAM @ 20-3f/a0-bf, offset 6000-7fff
      mapper_hirom, mapper_exhirom:
        sram_window = !addr[22] & addr[21] & (&addr[14:13]) & !addr[15];
      // Banks 70-7d/f0-fd; upper half only for small ROMs
      mapper_lorom:
        sram_window = (&addr[22:20]) & (addr[19:16] < 4'he)
                      & (~addr[15] | ~rom_mask[21]);
      mapper_menu:
        sram_window = &addr[23:16];
      default:
        sram_window = 1'b0;
    endcase
  end

  assign is_saveram = saveram_mask[0] & sram_window;
  assign is_rom     = addr[22] | addr[15];

  always_comb begin
    if (is_saveram)  region_d = region_saveram;
    else if (is_rom) region_d = region_rom;
    else             region_d = region_none;
  end

  ////////////////////
  // Peripheral selects
  ////////////////////

  assign msu   = featurebits[`FEAT_MSU1] & !addr[22]
                 & ((addr[15:0] & 16'hfff8) == 16'h2000);
  assign srtc  = featurebits[`FEAT_SRTC] & !addr[22]
                 & ((addr[15:0] & 16'hfffe) == 16'h2800);
  assign r213f = featurebits[`FEAT_213F] & (in.snes_pa == 8'h3f);
  assign cmd   = ({addr[22], addr[15:8]} == 9'b0_0010_1010);  // Command window

  always_comb begin
    dspx    = 1'b0;
    dspx_a0 = 1'b1;
    if (mapper == mapper_lorom) begin
      dspx_a0 = addr[14];  // DR/SR split
      if (rom_mask[20]) dspx = addr[22] & addr[21] & ~addr[20] & ~addr[15];
      else              dspx = ~addr[22] & addr[21] & addr[20] & addr[15];
    end else if (mapper == mapper_hirom) begin
      dspx_a0 = addr[12];
      dspx    = ~addr[22] & ~addr[21] & ~addr[20] & ~addr[15] & (&addr[14:13]);
    end
    dspx = dspx & featurebits[`FEAT_DSPX];
  end

  ////////////////////
  // Stage register
  ////////////////////

  always_ff @(posedge CLK) begin
    if (reset) out.valid <= 1'b0;
    else       out.valid <= in.valid;
  end

  always_ff @(posedge CLK) begin
    if (in.valid) begin
      out.kind      <= in.kind;
      out.snes_addr <= in.snes_addr;
      out.snes_pa   <= in.snes_pa;
      out.mem_addr  <= in.mem_addr;
      out.region    <= region_d;
      out.writable  <= (region_d == region_saveram);
      out.sel       <= {msu, srtc, dspx, dspx_a0, r213f, cmd};
    end
  end

  a_region_legal : assert property (@(posedge CLK) disable iff (reset)
    out.valid |-> out.region inside {region_none, region_rom, region_saveram});

endmodule

`default_nettype wire

/* source/address_translate.sv */
`default_nettype none
`include "snes_map_defines.svh"

module address_translate (
  input  logic                    CLK,
  input  logic                    reset,
  input  snes_map_pkg::mapper_e   mapper,
  input  logic [`SNES_ADDR_W-1:0] saveram_mask,
  input  logic [`SNES_ADDR_W-1:0] rom_mask,
  map_stage_if.dst                in,
  map_stage_if.src                out
);
  import snes_map_pkg::*;

  logic [`SNES_ADDR_W-1:0] addr;
  logic [`SNES_ADDR_W-1:0] sram_addr;
  logic [`SNES_ADDR_W-1:0] rom_addr;
  logic [`SNES_ADDR_W-1:0] mem_addr_d;

  assign addr = in.snes_addr;

  // Save RAM offset within its window
  always_comb begin
    case (mapper)
      mapper_hirom, mapper_exhirom:
        sram_addr = `SAVERAM_BASE
                    + ({6'b0, addr[20:16], addr[12:0]} & saveram_mask);
      mapper_lorom:
        sram_addr = `SAVERAM_BASE
                    + ({4'b0, addr[20:16], addr[14:0]} & saveram_mask);
      mapper_menu:
        sram_addr = addr;  // Menu sees memory directly
      default:
        sram_addr = '0;
    endcase
  end

  always_comb begin
    case (mapper)
      mapper_hirom:   rom_addr = {1'b0, addr[22:0]} & rom_mask;
      mapper_lorom:   rom_addr = {2'b00, addr[22:16], addr[14:0]} & rom_mask;
      // Banks c0-ff come first, then 40-7d
      mapper_exhirom: rom_addr = {1'b0, ~addr[23], addr[21:0]} & rom_mask;
      mapper_menu:    rom_addr = ({1'b0, addr[22:0]} & rom_mask) + `MENU_ROM_BASE;
      default:        rom_addr = '0;
    endcase
  end

  always_comb begin
    case (in.region)
      region_saveram: mem_addr_d = sram_addr;
      region_rom:     mem_addr_d = rom_addr;
      default:        mem_addr_d = '0;
    endcase
  end

  ////////////////////
  // Stage register
  ////////////////////

  always_ff @(posedge CLK) begin
    if (reset) out.valid <= 1'b0;
    else       out.valid <= in.valid;
  end

  always_ff @(posedge CLK) begin
    if (in.valid) begin
      out.kind      <= in.kind;
      out.snes_addr <= in.snes_addr;
      out.snes_pa   <= in.snes_pa;
      out.region    <= in.region;
      out.writable  <= in.writable;
      out.sel       <= in.sel;
      out.mem_addr  <= mem_addr_d;
    end
  end

endmodule

`default_nettype wire

/* source/mem_request.sv */
`default_nettype none
`include "snes_map_defines.svh"

module mem_request (
  input  logic                    CLK,
  input  logic                    reset,
  map_stage_if.dst                in,
  output logic                    mem_req,
  output logic                    mem_we,
  output logic [`SNES_ADDR_W-1:0] mem_addr,
  output logic                    wr_blocked,
  output logic                    msu_enable,
  output logic                    srtc_enable,
  output logic                    dspx_enable,
  output logic                    dspx_a0,
  output logic                    r213f_enable,
  output logic                    snescmd_enable
);
  import snes_map_pkg::*;

  logic is_write;
  logic has_mem;
  logic go;

  assign is_write = (in.kind == acc_write);
  assign has_mem  = (in.region != region_none);
  assign go       = has_mem & (!is_write | in.writable);  // Reads always, writes if allowed

  always_ff @(posedge CLK) begin
    if (reset) begin
      mem_req        <= 1'b0;
      mem_we         <= 1'b0;
      mem_addr       <= '0;
      wr_blocked     <= 1'b0;
      msu_enable     <= 1'b0;
      srtc_enable    <= 1'b0;
      dspx_enable    <= 1'b0;
      dspx_a0        <= 1'b0;
      r213f_enable   <= 1'b0;
      snescmd_enable <= 1'b0;
    end else begin
      mem_req    <= in.valid & go;
      wr_blocked <= in.valid & has_mem & is_write & !in.writable;  // ROM write
      if (in.valid) begin
        mem_we   <= go & is_write;
        mem_addr <= in.mem_addr;
        {msu_enable, srtc_enable, dspx_enable,
         dspx_a0, r213f_enable, snescmd_enable} <= in.sel;  // Held until next access
      end
    end
  end

  a_we_writable : assert property (@(posedge CLK) disable iff (reset)
    (mem_req && mem_we) |-> $past(in.writable));

endmodule

`default_nettype wire

/* source/snes_mapper_top.sv */
`default_nettype none
`include "snes_map_defines.svh"

module snes_mapper_top (
  input  logic                    CLK,
  input  logic                    reset,
  input  logic [`SNES_ADDR_W-1:0] snes_addr,
  input  logic [7:0]              snes_pa,
  input  logic                    snes_rd,
  input  logic                    snes_wr,
  input  snes_map_pkg::mapper_e   mapper,
  input  logic [7:0]              featurebits,
  input  logic [`SNES_ADDR_W-1:0] saveram_mask,
  input  logic [`SNES_ADDR_W-1:0] rom_mask,
  output logic                    mem_req,
  output logic                    mem_we,
  output logic [`SNES_ADDR_W-1:0] mem_addr,
  output logic                    wr_blocked,
  output logic                    msu_enable,
  output logic                    srtc_enable,
  output logic                    dspx_enable,
  output logic                    dspx_a0,
  output logic                    r213f_enable,
  output logic                    snescmd_enable
);

  map_stage_if cap2dec ();
  map_stage_if dec2xl ();
  map_stage_if xl2req ();

  bus_capture u_capture (
    .CLK, .reset, .snes_addr, .snes_pa, .snes_rd, .snes_wr,
    .out (cap2dec.src)
  );

  address_decode u_decode (
    .CLK, .reset, .mapper, .featurebits, .saveram_mask, .rom_mask,
    .in  (cap2dec.dst),
    .out (dec2xl.src)
  );

  address_translate u_translate (
    .CLK, .reset, .mapper, .saveram_mask, .rom_mask,
    .in  (dec2xl.dst),
    .out (xl2req.src)
  );

  mem_request u_request (
    .CLK, .reset,
    .in (xl2req.dst),
    .mem_req, .mem_we, .mem_addr, .wr_blocked,
    .msu_enable, .srtc_enable, .dspx_enable, .dspx_a0,
    .r213f_enable, .snescmd_enable
  );

endmodule

`default_nettype wire

/* sim/tb_snes_mapper.sv */
`default_nettype none
`include "snes_map_defines.svh"

module tb_snes_mapper;
  import snes_map_pkg::*;

  logic                    CLK;
  logic                    reset;
  logic [`SNES_ADDR_W-1:0] snes_addr;
  logic [7:0]              snes_pa;
  logic                    snes_rd;
  logic                    snes_wr;
  mapper_e                 mapper;
  logic [7:0]              featurebits;
  logic [`SNES_ADDR_W-1:0] saveram_mask;
  logic [`SNES_ADDR_W-1:0] rom_mask;
  logic                    mem_req;
  logic                    mem_we;
  logic [`SNES_ADDR_W-1:0] mem_addr;
  logic                    wr_blocked;
  logic                    msu_enable;
  logic                    srtc_enable;
  logic                    dspx_enable;
  logic                    dspx_a0;
  logic                    r213f_enable;
  logic                    snescmd_enable;

  int unsigned seed;
  int          checks;
  int          errors;
  int          timeouts;

  snes_mapper_top DUT (
    .CLK, .reset, .snes_addr, .snes_pa, .snes_rd, .snes_wr,
    .mapper, .featurebits, .saveram_mask, .rom_mask,
    .mem_req, .mem_we, .mem_addr, .wr_blocked,
    .msu_enable, .srtc_enable, .dspx_enable, .dspx_a0,
    .r213f_enable, .snescmd_enable
  );

  always #5 CLK = ~CLK;

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed;
  endfunction

  ////////////////////
  // Reference model
  ////////////////////

  function automatic region_e classify_region(logic [23:0] a);
    logic win;
    case (mapper)
      mapper_hirom, mapper_exhirom: win = !a[22] && a[21] && a[15:13] == 3'b011;
      mapper_lorom: win = a[22:20] == 3'b111 && a[19:16] < 4'he
                          && (!a[15] || !rom_mask[21]);
      mapper_menu:  win = a[23:16] == 8'hff;
      default:      win = 1'b0;
    endcase
    if (win && saveram_mask[0]) return region_saveram;
    if (a[22] || a[15]) return region_rom;
    return region_none;
  endfunction

  function automatic logic [23:0] translate_addr(logic [23:0] a, region_e r);
    logic [23:0] sram;
    logic [23:0] rom;
    case (mapper)
      mapper_lorom: begin
        sram = `SAVERAM_BASE + ({4'b0, a[20:16], a[14:0]} & saveram_mask);
        rom  = {2'b0, a[22:16], a[14:0]} & rom_mask;
      end
      mapper_exhirom: begin
        sram = `SAVERAM_BASE + ({6'b0, a[20:16], a[12:0]} & saveram_mask);
        rom  = {1'b0, ~a[23], a[21:0]} & rom_mask;
      end
      mapper_menu: begin
        sram = a;
        rom  = `MENU_ROM_BASE + ({1'b0, a[22:0]} & rom_mask);
      end
      default: begin
        sram = `SAVERAM_BASE + ({6'b0, a[20:16], a[12:0]} & saveram_mask);
        rom  = {1'b0, a[22:0]} & rom_mask;
      end
    endcase
    if (r == region_saveram) return sram;
    if (r == region_rom) return rom;
    return 24'h0;
  endfunction

  // Order msu, srtc, dspx, dspx_a0, r213f, cmd
  function automatic logic [5:0] decode_selects(logic [23:0] a, logic [7:0] pa);
    logic msu;
    logic srtc;
    logic dspx;
    logic a0;
    logic r3f;
    logic cmd;
    msu  = featurebits[`FEAT_MSU1] && !a[22] && a[15:0] >= 16'h2000 && a[15:0] <= 16'h2007;
    srtc = featurebits[`FEAT_SRTC] && !a[22] && a[15:0] >= 16'h2800 && a[15:0] <= 16'h2801;
    r3f  = featurebits[`FEAT_213F] && pa == 8'h3f;
    cmd  = !a[22] && a[15:8] == 8'h2a;
    dspx = 1'b0;
    a0   = 1'b1;
    if (mapper == mapper_lorom) begin
      a0   = a[14];
      dspx = rom_mask[20] ? (a[22:20] == 3'b110 && !a[15]) : (a[22:20] == 3'b011 && a[15]);
    end else if (mapper == mapper_hirom) begin
      a0   = a[12];
      dspx = a[22:20] == 3'b000 && a[15:13] == 3'b011;  // Banks 00-0f at 6000-7fff
    end
    dspx = dspx && featurebits[`FEAT_DSPX];
    return {msu, srtc, dspx, a0, r3f, cmd};
  endfunction

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic check_addr(string what, logic [23:0] got, logic [23:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(string what, logic got, logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s got %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_region(string what, region_e got, region_e exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s got %s, expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  task automatic set_config(mapper_e m, logic [7:0] f, logic [23:0] sm, logic [23:0] rm);
    mapper       = m;
    featurebits  = f;
    saveram_mask = sm;
    rom_mask     = rm;
  endtask

  // One strobe of two cycles and the wait for its result
  task automatic do_access(access_e kind, logic [23:0] a, logic [7:0] pa);
    region_e     exp_region;
    logic [23:0] exp_addr;
    logic [5:0]  exp_sel;
    logic        exp_req;
    logic        exp_blk;
    logic        seen;
    int          cyc;
    int          limit;
    string       tag;
    exp_region = classify_region(a);
    exp_addr   = translate_addr(a, exp_region);
    exp_sel    = decode_selects(a, pa);
    exp_req    = exp_region != region_none
                 && (kind == acc_read || exp_region == region_saveram);
    exp_blk    = exp_region == region_rom && kind == acc_write;
    tag        = $sformatf("%s %h", kind.name(), a);
    @(posedge CLK);
    #1;
    snes_addr = a;
    snes_pa   = pa;
    snes_rd   = (kind == acc_read);
    snes_wr   = (kind == acc_write);
    repeat (2) @(posedge CLK);  // Edges k and k+1
    #1;
    snes_rd = 1'b0;
    snes_wr = 1'b0;
    limit   = (exp_req || exp_blk) ? 20 : 6;
    cyc     = 1;
    seen    = 1'b0;
    while (!seen && cyc < limit) begin
      @(posedge CLK);
      cyc++;
      @(negedge CLK);
      seen = mem_req | wr_blocked;
    end
    if ((exp_req || exp_blk) && !seen) begin
      timeouts++;
      $display("Timeout: no request or blocked write for %s within %0d cycles", tag, limit);
      return;
    end
    check_bit({tag, " output after four cycles"}, !seen || cyc == 4, 1'b1);
    check_bit({tag, " mem_req"}, mem_req, exp_req);
    check_bit({tag, " wr_blocked"}, wr_blocked, exp_blk);
    check_bit({tag, " mem_we"}, mem_we, exp_req && kind == acc_write);
    check_addr({tag, " mem_addr"}, mem_addr, exp_addr);
    check_region({tag, " region"}, DUT.xl2req.region, exp_region);
    check_bit({tag, " msu"}, msu_enable, exp_sel[5]);
    check_bit({tag, " srtc"}, srtc_enable, exp_sel[4]);
    check_bit({tag, " dspx"}, dspx_enable, exp_sel[3]);
    check_bit({tag, " dspx_a0"}, dspx_a0, exp_sel[2]);
    check_bit({tag, " r213f"}, r213f_enable, exp_sel[1]);
    check_bit({tag, " cmd"}, snescmd_enable, exp_sel[0]);
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic idle_outputs();
    repeat (5) begin
      @(negedge CLK);
      check_bit("idle mem_req", mem_req, 1'b0);
      check_bit("idle mem_we", mem_we, 1'b0);
      check_bit("idle wr_blocked", wr_blocked, 1'b0);
      check_addr("idle mem_addr", mem_addr, 24'h0);
      check_bit("idle selects", |{msu_enable, srtc_enable, dspx_enable, dspx_a0,
                                  r213f_enable, snescmd_enable}, 1'b0);
    end
  endtask

  task automatic random_reads(int n);
    logic [31:0] r;
    logic [31:0] p;
    for (int i = 0; i < n; i++) begin
      r = lcg_next();
      p = lcg_next();
      do_access(acc_read, r[31:8], p[31:24]);
    end
  endtask

  task automatic mapper_reads();
    set_config(mapper_hirom, 8'h00, 24'h001fff, 24'h3fffff);
    random_reads(32);
    set_config(mapper_lorom, 8'h00, 24'h007fff, 24'h3fffff);  // rom_mask bit 21 set
    random_reads(16);
    set_config(mapper_lorom, 8'h00, 24'h007fff, 24'h0fffff);
    random_reads(16);
    set_config(mapper_exhirom, 8'h00, 24'h001fff, 24'h7fffff);
    random_reads(32);
    set_config(mapper_menu, 8'h00, 24'h01ffff, 24'h1fffff);
    random_reads(32);
  endtask

  task automatic write_accesses();
    set_config(mapper_hirom, 8'h00, 24'h001fff, 24'h3fffff);
    do_access(acc_write, 24'h206123, 8'h00);
    do_access(acc_read, 24'h207fff, 8'h00);
    do_access(acc_write, 24'hc01234, 8'h00);
    do_access(acc_write, 24'h001000, 8'h00);  // No memory behind it
    set_config(mapper_lorom, 8'h00, 24'h007fff, 24'h3fffff);
    do_access(acc_write, 24'h700010, 8'h00);
    do_access(acc_write, 24'h008000, 8'h00);
    set_config(mapper_exhirom, 8'h00, 24'h001fff, 24'h7fffff);
    do_access(acc_write, 24'h306000, 8'h00);
    do_access(acc_write, 24'h400000, 8'h00);
    set_config(mapper_menu, 8'h00, 24'h01ffff, 24'h1fffff);
    do_access(acc_write, 24'hff1234, 8'h00);
    do_access(acc_write, 24'hc08000, 8'h00);
  endtask

  task automatic feature_selects();
    logic [23:0] hi_list[11];
    logic [7:0]  f_list[6];
    logic [7:0]  f;
    hi_list = '{24'h002100, 24'h002003, 24'h002800, 24'h002801, 24'h002808, 24'h002a10,
                24'h402a10, 24'h006000, 24'h007000, 24'h106000, 24'h002007};
    f_list  = '{8'h1d, 8'h01, 8'h04, 8'h08, 8'h10, 8'h00};  // All, each alone, none
    for (int j = 0; j < 6; j++) begin
      f = f_list[j];
      set_config(mapper_hirom, f, 24'h001fff, 24'h3fffff);
      for (int i = 0; i < 11; i++) do_access(acc_read, hi_list[i], (i == 0) ? 8'h3f : 8'h3e);
      set_config(mapper_lorom, f, 24'h007fff, 24'h3fffff);  // DSP in banks 60-6f low half
      do_access(acc_read, 24'h600000, 8'h00);
      do_access(acc_read, 24'h604000, 8'h00);
      do_access(acc_read, 24'h608000, 8'h00);
      set_config(mapper_lorom, f, 24'h007fff, 24'h0fffff);  // DSP in banks 30-3f upper half
      do_access(acc_read, 24'h308000, 8'h00);
      do_access(acc_read, 24'h30c000, 8'h00);
      set_config(mapper_exhirom, f, 24'h001fff, 24'h7fffff);
      do_access(acc_read, 24'h006000, 8'h3f);
    end
  endtask

  // Four reads with a strobe every second cycle
  task automatic back_to_back_reads();
    logic [23:0] addrs[4];
    logic [31:0] r;
    int          got;
    set_config(mapper_hirom, 8'h00, 24'h001fff, 24'h3fffff);
    for (int i = 0; i < 4; i++) begin
      r        = lcg_next();
      addrs[i] = r[31:8] | 24'h008000;  // Always ROM
    end
    got = 0;
    for (int cyc = 0; cyc < 20 && got < 4; cyc++) begin
      @(posedge CLK);
      #1;
      if (cyc % 2 == 0 && cyc / 2 < 4) begin
        snes_addr = addrs[cyc / 2];
        snes_rd   = 1'b1;
      end else begin
        snes_rd = 1'b0;
      end
      @(negedge CLK);
      if (mem_req) begin
        check_bit($sformatf("pipelined read %0d latency", got), cyc == 5 + 2 * got, 1'b1);
        check_addr($sformatf("pipelined read %0d mem_addr", got), mem_addr,
                   translate_addr(addrs[got], classify_region(addrs[got])));
        got++;
      end
    end
    if (got != 4) begin
      timeouts++;
      $display("Timeout: only %0d of 4 pipelined reads produced a request", got);
    end
  endtask

  initial begin
    CLK       = 1'b0;
    reset     = 1'b1;
    snes_addr = '0;
    snes_pa   = '0;
    snes_rd   = 1'b0;
    snes_wr   = 1'b0;
    set_config(mapper_hirom, 8'h00, 24'h001fff, 24'h3fffff);
    seed      = 33645;
    checks    = 0;
    errors    = 0;
    timeouts  = 0;
    repeat (5) @(posedge CLK);
    #1 reset = 1'b0;

    idle_outputs();
    mapper_reads();
    write_accesses();
    feature_selects();
    back_to_back_reads();

    $display("Checks: %0d, mismatches: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
+incdir+source
source/snes_map_pkg.sv
source/map_stage_if.sv
source/bus_capture.sv
source/address_decode.sv
source/address_translate.sv
source/mem_request.sv
source/snes_mapper_top.sv
sim/tb_snes_mapper.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the mapper testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tb_snes_mapper -o sim_snes_mapper

./obj_dir/sim_snes_mapper > sim.log 2>&1
cat sim.log

if grep -q "Simulation failed" sim.log; then
  echo "Testbench reported failure"
  exit 1
fi
exit 0
